//--- biriq_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "biriq_params.svh"

module biriq_core (
  input  wire                      cpu_clock_i,
  input  wire                      rst_n_i,
  input  biriq_pipe_pkg::bundle_t  bundle_i,
  input  wire                      bundle_vld_i,
  output biriq_pipe_pkg::commit_t  commit0_o,
  output biriq_pipe_pkg::commit_t  commit1_o
);

  biriq_pipe_pkg::uop_t    uop0;
  biriq_pipe_pkg::uop_t    uop1;
  biriq_pipe_pkg::commit_t ex0;
  biriq_pipe_pkg::commit_t ex1;

  // Two source operands per slot
  logic [2*`BIRIQ_ISSUE_W-1:0][`BIRIQ_REG_AW-1:0] rd_addr;
  logic [2*`BIRIQ_ISSUE_W-1:0][`BIRIQ_XLEN-1:0]   rd_data;

  biriq_decode u_decode (
    .cpu_clock_i  (cpu_clock_i),
    .rst_n_i      (rst_n_i),
    .bundle_i     (bundle_i),
    .bundle_vld_i (bundle_vld_i),
    .uop0_o       (uop0),
    .uop1_o       (uop1)
  );

  biriq_execute u_execute (
    .cpu_clock_i (cpu_clock_i),
    .rst_n_i     (rst_n_i),
    .uop0_i      (uop0),
    .uop1_i      (uop1),
    .rd_addr_o   (rd_addr),
    .rd_data_i   (rd_data),
    .ex0_o       (ex0),
    .ex1_o       (ex1)
  );

  // Register file, operand bypass and write-back
  biriq_result u_result (
    .cpu_clock_i (cpu_clock_i),
    .rst_n_i     (rst_n_i),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (rd_data),
    .ex0_i       (ex0),
    .ex1_i       (ex1),
    .commit0_o   (commit0_o),
    .commit1_o   (commit1_o)
  );

endmodule

`default_nettype wire

//--- biriq_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "biriq_params.svh"

module biriq_decode (
  input  wire                    cpu_clock_i,
  input  wire                    rst_n_i,
  input  biriq_pipe_pkg::bundle_t bundle_i,
  input  wire                    bundle_vld_i,
  output biriq_pipe_pkg::uop_t   uop0_o,
  output biriq_pipe_pkg::uop_t   uop1_o
);

  // Turns one instruction word into a micro-operation, vld is added later
  function automatic biriq_pipe_pkg::uop_t decode_slot(input logic [`BIRIQ_XLEN-1:0] ins);
    biriq_pipe_pkg::uop_t u;
    logic [2:0]           f3;
    logic [6:0]           f7;
    f3 = ins[14:12];
    f7 = ins[31:25];
    u = '0;
    u.rd = ins[11:7];
    u.rs1 = ins[19:15];
    u.rs2 = ins[24:20];
    u.alu_op = biriq_isa_pkg::ADD;
    case (ins[6:0])
      biriq_isa_pkg::OP: begin
        // Only add and right shift have an alternate funct7
        u.illegal = !(f7 == biriq_isa_pkg::F7_BASE ||
                      (f7 == biriq_isa_pkg::F7_ALT &&
                       (f3 == biriq_isa_pkg::F3_ADD_SUB || f3 == biriq_isa_pkg::F3_SRL_SRA)));
        case (f3)
          biriq_isa_pkg::F3_ADD_SUB: u.alu_op = (f7 == biriq_isa_pkg::F7_ALT) ?
                                                biriq_isa_pkg::SUB : biriq_isa_pkg::ADD;
          biriq_isa_pkg::F3_SLL:     u.alu_op = biriq_isa_pkg::SLL;
          biriq_isa_pkg::F3_SLT:     u.alu_op = biriq_isa_pkg::SLT;
          biriq_isa_pkg::F3_SLTU:    u.alu_op = biriq_isa_pkg::SLTU;
          biriq_isa_pkg::F3_XOR:     u.alu_op = biriq_isa_pkg::XOR;
          biriq_isa_pkg::F3_SRL_SRA: u.alu_op = (f7 == biriq_isa_pkg::F7_ALT) ?
                                                biriq_isa_pkg::SRA : biriq_isa_pkg::SRL;
          biriq_isa_pkg::F3_OR:      u.alu_op = biriq_isa_pkg::OR;
          default:                   u.alu_op = biriq_isa_pkg::AND;
        endcase
      end
      biriq_isa_pkg::OP_IMM: begin
        u.rs2_is_imm = 1'b1;
        u.imm = {{(`BIRIQ_XLEN-12){ins[31]}}, ins[31:20]};
        case (f3)
          biriq_isa_pkg::F3_ADD_SUB: u.alu_op = biriq_isa_pkg::ADD;
          biriq_isa_pkg::F3_SLL: begin
            u.alu_op = biriq_isa_pkg::SLL;
            u.illegal = (f7 != biriq_isa_pkg::F7_BASE);
          end
          biriq_isa_pkg::F3_SLT:     u.alu_op = biriq_isa_pkg::SLT;
          biriq_isa_pkg::F3_SLTU:    u.alu_op = biriq_isa_pkg::SLTU;
          biriq_isa_pkg::F3_XOR:     u.alu_op = biriq_isa_pkg::XOR;
          biriq_isa_pkg::F3_SRL_SRA: begin
            // Upper immediate bits act as funct7 for the shift forms
            u.alu_op = (f7 == biriq_isa_pkg::F7_ALT) ? biriq_isa_pkg::SRA : biriq_isa_pkg::SRL;
            u.illegal = (f7 != biriq_isa_pkg::F7_BASE) && (f7 != biriq_isa_pkg::F7_ALT);
          end
          biriq_isa_pkg::F3_OR:      u.alu_op = biriq_isa_pkg::OR;
          default:                   u.alu_op = biriq_isa_pkg::AND;
        endcase
      end
      biriq_isa_pkg::LUI: begin
        u.alu_op = biriq_isa_pkg::PASS_B;
        u.rs2_is_imm = 1'b1;
        u.rs1_is_zero_src = 1'b1;
        u.imm = {ins[31:12], 12'b0};
      end
      default: u.illegal = 1'b1;
    endcase
    return u;
  endfunction

  logic [`BIRIQ_ISSUE_W-1:0] vld_q;
  biriq_pipe_pkg::uop_t      uop0_q;
  biriq_pipe_pkg::uop_t      uop1_q;

  always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= bundle_i.slot_vld & {`BIRIQ_ISSUE_W{bundle_vld_i}};
    end
  end

  // Payload only moves when a bundle is offered
  always_ff @(posedge cpu_clock_i) begin
    if (bundle_vld_i) begin
      uop0_q <= decode_slot(bundle_i.ins0);
      uop1_q <= decode_slot(bundle_i.ins1);
    end
  end

  always_comb begin
    uop0_o = uop0_q;
    uop0_o.vld = vld_q[0];
    uop1_o = uop1_q;
    uop1_o.vld = vld_q[1];
  end

endmodule

`default_nettype wire

//--- biriq_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "biriq_params.svh"

module biriq_execute (
  input  wire                                             cpu_clock_i,
  input  wire                                             rst_n_i,
  input  biriq_pipe_pkg::uop_t                            uop0_i,
  input  biriq_pipe_pkg::uop_t                            uop1_i,
  output logic [2*`BIRIQ_ISSUE_W-1:0][`BIRIQ_REG_AW-1:0]  rd_addr_o,
  input  wire  [2*`BIRIQ_ISSUE_W-1:0][`BIRIQ_XLEN-1:0]    rd_data_i,
  output biriq_pipe_pkg::commit_t                         ex0_o,
  output biriq_pipe_pkg::commit_t                         ex1_o
);

  function automatic logic [`BIRIQ_XLEN-1:0] alu_eval(input biriq_isa_pkg::alu_op_e op,
                                                      input logic [`BIRIQ_XLEN-1:0] a,
                                                      input logic [`BIRIQ_XLEN-1:0] b);
    logic [biriq_isa_pkg::SHAMT_W-1:0] shamt;
    logic [`BIRIQ_XLEN-1:0]            res;
    shamt = b[biriq_isa_pkg::SHAMT_W-1:0];
    case (op)
      biriq_isa_pkg::ADD:    res = a + b;
      biriq_isa_pkg::SUB:    res = a - b;
      biriq_isa_pkg::SLL:    res = a << shamt;
      biriq_isa_pkg::SLT:    res = {{(`BIRIQ_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      biriq_isa_pkg::SLTU:   res = {{(`BIRIQ_XLEN-1){1'b0}}, a < b};
      biriq_isa_pkg::XOR:    res = a ^ b;
      biriq_isa_pkg::SRL:    res = a >> shamt;
      biriq_isa_pkg::SRA:    res = $unsigned($signed(a) >>> shamt);
      biriq_isa_pkg::OR:     res = a | b;
      biriq_isa_pkg::AND:    res = a & b;
      biriq_isa_pkg::PASS_B: res = b;
      default:               res = '0;
    endcase
    return res;
  endfunction

  logic                    dep_ok;
  logic                    chain_a;
  logic                    chain_b;
  logic [`BIRIQ_XLEN-1:0]  a0;
  logic [`BIRIQ_XLEN-1:0]  b0;
  logic [`BIRIQ_XLEN-1:0]  a1;
  logic [`BIRIQ_XLEN-1:0]  b1;
  logic [`BIRIQ_XLEN-1:0]  alu0;
  logic [`BIRIQ_XLEN-1:0]  alu1;
  logic [1:0]              ex_vld_q;
  biriq_pipe_pkg::commit_t ex0_q;
  biriq_pipe_pkg::commit_t ex1_q;

  // Read ports 0 and 1 serve slot 0, ports 2 and 3 serve slot 1
  assign rd_addr_o[0] = uop0_i.rs1;
  assign rd_addr_o[1] = uop0_i.rs2;
  assign rd_addr_o[2] = uop1_i.rs1;
  assign rd_addr_o[3] = uop1_i.rs2;

  // Slot 1 takes ALU0's fresh result when it reads what slot 0 writes
  assign dep_ok  = uop0_i.vld && !uop0_i.illegal && (uop0_i.rd != '0);
  assign chain_a = dep_ok && !uop1_i.rs1_is_zero_src && (uop1_i.rs1 == uop0_i.rd);
  assign chain_b = dep_ok && !uop1_i.rs2_is_imm && (uop1_i.rs2 == uop0_i.rd);

  assign a0 = uop0_i.rs1_is_zero_src ? '0 : rd_data_i[0];
  assign b0 = uop0_i.rs2_is_imm ? uop0_i.imm : rd_data_i[1];
  assign alu0 = alu_eval(uop0_i.alu_op, a0, b0);

  assign a1 = uop1_i.rs1_is_zero_src ? '0 : (chain_a ? alu0 : rd_data_i[2]);
  assign b1 = uop1_i.rs2_is_imm ? uop1_i.imm : (chain_b ? alu0 : rd_data_i[3]);
  assign alu1 = alu_eval(uop1_i.alu_op, a1, b1);

  always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_vld_q <= '0;
    end else begin
      ex_vld_q <= {uop1_i.vld, uop0_i.vld};
    end
  end

  // Illegal slots report a zero value
  always_ff @(posedge cpu_clock_i) begin
    ex0_q <= '{vld: 1'b0, illegal: uop0_i.illegal, rd: uop0_i.rd,
               value: uop0_i.illegal ? '0 : alu0};
    ex1_q <= '{vld: 1'b0, illegal: uop1_i.illegal, rd: uop1_i.rd,
               value: uop1_i.illegal ? '0 : alu1};
  end

  always_comb begin
    ex0_o = ex0_q;
    ex0_o.vld = ex_vld_q[0];
    ex1_o = ex1_q;
    ex1_o.vld = ex_vld_q[1];
  end

endmodule

`default_nettype wire

//--- biriq_isa_pkg.sv
`default_nettype none

`include "biriq_params.svh"

package biriq_isa_pkg;

  // Major opcodes of the RV32I subset handled by this pipeline
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_e;

  // ALU operations, PASS_B forwards the second operand unchanged
  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SLT    = 4'd3,
    SLTU   = 4'd4,
    XOR    = 4'd5,
    SRL    = 4'd6,
    SRA    = 4'd7,
    OR     = 4'd8,
    AND    = 4'd9,
    PASS_B = 4'd10
  } alu_op_e;

  // funct3 codes shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 selects the alternate form of add and right shift
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // Shift amount width follows the data width
  localparam int unsigned SHAMT_W = $clog2(`BIRIQ_XLEN);

endpackage

`default_nettype wire

//--- biriq_params.svh
`ifndef BIRIQ_PARAMS_SVH
`define BIRIQ_PARAMS_SVH

// Data path and instruction word width
`define BIRIQ_XLEN 32

// Architectural integer registers, x0 included
`define BIRIQ_NUM_REGS 32

// Bits needed to address one architectural register
`define BIRIQ_REG_AW 5

// Instruction slots per issued bundle
`define BIRIQ_ISSUE_W 2

`endif

//--- biriq_pipe_pkg.sv
`default_nettype none

`include "biriq_params.svh"

package biriq_pipe_pkg;

  // Two instruction words as presented to decode
  typedef struct packed {
    logic [`BIRIQ_XLEN-1:0]    ins0;
    logic [`BIRIQ_XLEN-1:0]    ins1;
    logic [`BIRIQ_ISSUE_W-1:0] slot_vld;
  } bundle_t;

  // One decoded slot on its way to execute
  typedef struct packed {
    logic                    vld;
    logic                    illegal;
    biriq_isa_pkg::alu_op_e  alu_op;
    logic [`BIRIQ_REG_AW-1:0] rs1;
    logic [`BIRIQ_REG_AW-1:0] rs2;
    logic                    rs2_is_imm;
    logic [`BIRIQ_REG_AW-1:0] rd;
    logic [`BIRIQ_XLEN-1:0]  imm;
    // Set for lui so that the first ALU operand is zero and rs1 is not read
    logic                    rs1_is_zero_src;
  } uop_t;

  // Result of one slot, used for write-back and reported at the top level
  typedef struct packed {
    logic                     vld;
    logic                     illegal;
    logic [`BIRIQ_REG_AW-1:0] rd;
    logic [`BIRIQ_XLEN-1:0]   value;
  } commit_t;

endpackage

`default_nettype wire

//--- biriq_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "biriq_params.svh"

module biriq_result (
  input  wire                                             cpu_clock_i,
  input  wire                                             rst_n_i,
  input  wire  [2*`BIRIQ_ISSUE_W-1:0][`BIRIQ_REG_AW-1:0]  rd_addr_i,
  output logic [2*`BIRIQ_ISSUE_W-1:0][`BIRIQ_XLEN-1:0]    rd_data_o,
  input  biriq_pipe_pkg::commit_t                         ex0_i,
  input  biriq_pipe_pkg::commit_t                         ex1_i,
  output biriq_pipe_pkg::commit_t                         commit0_o,
  output biriq_pipe_pkg::commit_t                         commit1_o
);

  // x0 is not stored, reads of it are forced to zero
  logic [`BIRIQ_XLEN-1:0] regs [`BIRIQ_NUM_REGS-1:1];
  logic                   we0;
  logic                   we1;

  assign we0 = ex0_i.vld && !ex0_i.illegal && (ex0_i.rd != '0);
  assign we1 = ex1_i.vld && !ex1_i.illegal && (ex1_i.rd != '0);

  // Slot 1 is younger, so it wins when both slots target the same register
  always_ff @(posedge cpu_clock_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `BIRIQ_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 1; i < `BIRIQ_NUM_REGS; i++) begin
        if (we1 && ex1_i.rd == `BIRIQ_REG_AW'(i)) begin
          regs[i] <= ex1_i.value;
        end else if (we0 && ex0_i.rd == `BIRIQ_REG_AW'(i)) begin
          regs[i] <= ex0_i.value;
        end
      end
    end
  end

  // Results still in the execute register are forwarded ahead of the file
  always_comb begin
    for (int p = 0; p < 2*`BIRIQ_ISSUE_W; p++) begin
      if (rd_addr_i[p] == '0) begin
        rd_data_o[p] = '0;
      end else if (we1 && ex1_i.rd == rd_addr_i[p]) begin
        rd_data_o[p] = ex1_i.value;
      end else if (we0 && ex0_i.rd == rd_addr_i[p]) begin
        rd_data_o[p] = ex0_i.value;
      end else begin
        rd_data_o[p] = regs[rd_addr_i[p]];
      end
    end
  end

  // Commit records leave in the same cycle they are written back
  assign commit0_o = ex0_i;
  assign commit1_o = ex1_i;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run the simulation and judge the result from its log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --top-module tb_biriq -f src.f > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_biriq > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "RESULT: FAIL"; exit 1; } \
  || { echo "RESULT: PASS"; exit 0; }

//--- src.f
+incdir+.
biriq_isa_pkg.sv
biriq_pipe_pkg.sv
biriq_decode.sv
biriq_execute.sv
biriq_result.sv
biriq_core.sv
tb_clock_gen.sv
tb_biriq.sv

//--- tb_biriq.sv
`timescale 1ns/1ps
`default_nettype none

`include "biriq_params.svh"

module tb_biriq;

  localparam int RESET_CYCLES = 16;
  localparam int WAIT_LIMIT = 50;

  logic                    cpu_clock;
  logic                    rst_n;
  biriq_pipe_pkg::bundle_t bundle;
  logic                    bundle_vld;
  biriq_pipe_pkg::commit_t commit0;
  biriq_pipe_pkg::commit_t commit1;

  // Stimulus and expected commit records, one element per table entry
  string                   names[$];
  biriq_pipe_pkg::bundle_t bundles[$];
  logic                    vlds[$];
  biriq_pipe_pkg::commit_t exp0_q[$];
  biriq_pipe_pkg::commit_t exp1_q[$];

  // Rising edges seen since reset was released
  int cycle = 0;

  tb_clock_gen #(.PERIOD_NS(20)) u_clock (
    .clk_o (cpu_clock)
  );

  biriq_core u_dut (
    .cpu_clock_i  (cpu_clock),
    .rst_n_i      (rst_n),
    .bundle_i     (bundle),
    .bundle_vld_i (bundle_vld),
    .commit0_o    (commit0),
    .commit1_o    (commit1)
  );

  always @(posedge cpu_clock) begin
    if (rst_n) begin
      cycle <= cycle + 1;
    end
  end

  function automatic logic [`BIRIQ_XLEN-1:0] rr_word(input logic [6:0] f7, input logic [2:0] f3,
                                                     input int rd, input int rs1, input int rs2);
    return {f7, rs2[`BIRIQ_REG_AW-1:0], rs1[`BIRIQ_REG_AW-1:0], f3, rd[`BIRIQ_REG_AW-1:0],
            biriq_isa_pkg::OP};
  endfunction

  function automatic logic [`BIRIQ_XLEN-1:0] ri_word(input logic [2:0] f3, input int rd,
                                                     input int rs1, input logic [11:0] imm);
    return {imm, rs1[`BIRIQ_REG_AW-1:0], f3, rd[`BIRIQ_REG_AW-1:0], biriq_isa_pkg::OP_IMM};
  endfunction

  function automatic logic [`BIRIQ_XLEN-1:0] lui_word(input int rd, input logic [19:0] imm);
    return {imm, rd[`BIRIQ_REG_AW-1:0], biriq_isa_pkg::LUI};
  endfunction

  function automatic biriq_pipe_pkg::commit_t legal_commit(input int rd,
                                                           input logic [`BIRIQ_XLEN-1:0] value);
    biriq_pipe_pkg::commit_t c;
    c.vld = 1'b1;
    c.illegal = 1'b0;
    c.rd = rd[`BIRIQ_REG_AW-1:0];
    c.value = value;
    return c;
  endfunction

  // An illegal slot still commits and reports a zero value
  function automatic biriq_pipe_pkg::commit_t illegal_commit(input int rd);
    biriq_pipe_pkg::commit_t c;
    c.vld = 1'b1;
    c.illegal = 1'b1;
    c.rd = rd[`BIRIQ_REG_AW-1:0];
    c.value = '0;
    return c;
  endfunction

  function automatic biriq_pipe_pkg::commit_t no_commit();
    return '0;
  endfunction

  task automatic add_entry(input string name, input logic [`BIRIQ_XLEN-1:0] ins0,
                           input logic [`BIRIQ_XLEN-1:0] ins1, input logic [1:0] slots,
                           input logic vld, input biriq_pipe_pkg::commit_t e0,
                           input biriq_pipe_pkg::commit_t e1);
    biriq_pipe_pkg::bundle_t b;
    b.ins0 = ins0;
    b.ins1 = ins1;
    b.slot_vld = slots;
    names.push_back(name);
    bundles.push_back(b);
    vlds.push_back(vld);
    exp0_q.push_back(e0);
    exp1_q.push_back(e1);
  endtask

  task automatic build_table();
    int last;
    add_entry("idle", 32'h0, 32'h0, 2'b00, 1'b0, no_commit(), no_commit());
    // No source register of the ALU section is ever rewritten with a new value
    add_entry("addi_from_x0", ri_word(3'b000, 1, 0, 12'd5), ri_word(3'b000, 2, 0, 12'hffd),
              2'b11, 1'b1, legal_commit(1, 32'd5), legal_commit(2, 32'hffff_fffd));
    add_entry("add_sub", rr_word(7'h00, 3'b000, 3, 1, 2), rr_word(7'h20, 3'b000, 4, 1, 2),
              2'b11, 1'b1, legal_commit(3, 32'd2), legal_commit(4, 32'd8));
    add_entry("slt_sltu", rr_word(7'h00, 3'b010, 5, 2, 1), rr_word(7'h00, 3'b011, 6, 2, 1),
              2'b11, 1'b1, legal_commit(5, 32'd1), legal_commit(6, 32'd0));
    add_entry("lui_pair", lui_word(7, 20'h80000), lui_word(8, 20'h12345),
              2'b11, 1'b1, legal_commit(7, 32'h8000_0000), legal_commit(8, 32'h1234_5000));
    add_entry("sll_srl", rr_word(7'h00, 3'b001, 9, 8, 5), rr_word(7'h00, 3'b101, 10, 7, 4),
              2'b11, 1'b1, legal_commit(9, 32'h2468_a000), legal_commit(10, 32'h0080_0000));
    add_entry("sra_xor", rr_word(7'h20, 3'b101, 11, 7, 4), rr_word(7'h00, 3'b100, 12, 1, 2),
              2'b11, 1'b1, legal_commit(11, 32'hff80_0000), legal_commit(12, 32'hffff_fff8));
    add_entry("or_and", rr_word(7'h00, 3'b110, 13, 1, 8), rr_word(7'h00, 3'b111, 14, 11, 12),
              2'b11, 1'b1, legal_commit(13, 32'h1234_5005), legal_commit(14, 32'hff80_0000));
    add_entry("slti_sltiu", ri_word(3'b010, 15, 2, 12'hffe), ri_word(3'b011, 16, 2, 12'd3),
              2'b11, 1'b1, legal_commit(15, 32'd1), legal_commit(16, 32'd0));
    add_entry("xori_ori", ri_word(3'b100, 17, 1, 12'hfff), ri_word(3'b110, 18, 3, 12'h7f0),
              2'b11, 1'b1, legal_commit(17, 32'hffff_fffa), legal_commit(18, 32'h0000_07f2));
    add_entry("andi_slli", ri_word(3'b111, 19, 12, 12'h0ff), ri_word(3'b001, 20, 1, 12'h004),
              2'b11, 1'b1, legal_commit(19, 32'h0000_00f8), legal_commit(20, 32'h0000_0050));
    add_entry("srli_srai", ri_word(3'b101, 21, 7, 12'h004), ri_word(3'b101, 22, 7, 12'h404),
              2'b11, 1'b1, legal_commit(21, 32'h0800_0000), legal_commit(22, 32'hf800_0000));
    // Same operations again with the slots swapped, so every one runs in both ALUs
    last = names.size() - 1;
    for (int i = 1; i <= last; i++) begin
      add_entry({names[i], "_swapped"}, bundles[i].ins1, bundles[i].ins0, 2'b11, 1'b1,
                exp1_q[i], exp0_q[i]);
    end
    add_entry("chain_rs1", ri_word(3'b000, 23, 1, 12'd10), rr_word(7'h00, 3'b000, 24, 23, 23),
              2'b11, 1'b1, legal_commit(23, 32'd15), legal_commit(24, 32'd30));
    add_entry("chain_imm", ri_word(3'b000, 25, 0, 12'd100), ri_word(3'b001, 26, 25, 12'd2),
              2'b11, 1'b1, legal_commit(25, 32'd100), legal_commit(26, 32'h0000_0190));
    add_entry("same_rd", ri_word(3'b000, 27, 0, 12'd7), ri_word(3'b000, 27, 0, 12'd9),
              2'b11, 1'b1, legal_commit(27, 32'd7), legal_commit(27, 32'd9));
    add_entry("same_rd_bypass", rr_word(7'h00, 3'b000, 28, 27, 0), ri_word(3'b000, 29, 27, 12'd1),
              2'b11, 1'b1, legal_commit(28, 32'd9), legal_commit(29, 32'd10));
    add_entry("same_rd_regfile", ri_word(3'b000, 30, 27, 12'd0),
              rr_word(7'h00, 3'b000, 31, 28, 29),
              2'b11, 1'b1, legal_commit(30, 32'd9), legal_commit(31, 32'd19));
    // Slot 0 has opcode 7'h7f and slot 1 is an add with funct7 7'h01
    add_entry("illegal", 32'h0000_02ff, rr_word(7'h01, 3'b000, 8, 1, 1),
              2'b11, 1'b1, illegal_commit(5), illegal_commit(8));
    add_entry("illegal_keeps_rd", rr_word(7'h00, 3'b000, 23, 5, 0),
              rr_word(7'h00, 3'b000, 24, 8, 0),
              2'b11, 1'b1, legal_commit(23, 32'd1), legal_commit(24, 32'h1234_5000));
    add_entry("x0_write", ri_word(3'b000, 0, 0, 12'd123), rr_word(7'h00, 3'b000, 25, 0, 0),
              2'b11, 1'b1, legal_commit(0, 32'd123), legal_commit(25, 32'd0));
    // Slot 1 also reads x5 from the register file, where the illegal write was dropped
    add_entry("x0_read", rr_word(7'h00, 3'b000, 26, 0, 0), rr_word(7'h00, 3'b110, 27, 0, 5),
              2'b11, 1'b1, legal_commit(26, 32'd0), legal_commit(27, 32'd1));
    add_entry("empty_slot1", ri_word(3'b000, 28, 1, 12'd1), ri_word(3'b000, 29, 0, 12'd55),
              2'b01, 1'b1, legal_commit(28, 32'd6), no_commit());
    add_entry("empty_slot1_read", rr_word(7'h00, 3'b000, 30, 29, 0),
              rr_word(7'h00, 3'b000, 31, 28, 0),
              2'b11, 1'b1, legal_commit(30, 32'd10), legal_commit(31, 32'd6));
    add_entry("bundle_vld_low", ri_word(3'b000, 1, 0, 12'd77), ri_word(3'b000, 2, 0, 12'd88),
              2'b11, 1'b0, no_commit(), no_commit());
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // Only vld is defined for a slot that does not commit
  task automatic check_commit(input string name, input biriq_pipe_pkg::commit_t expected,
                              input biriq_pipe_pkg::commit_t actual);
    if (expected.vld) begin
      check_value(name, 64'(expected), 64'(actual));
    end else begin
      check_value(name, 64'(expected.vld), 64'(actual.vld));
    end
  endtask

  task automatic wait_to_cycle(input int target, input string what);
    int spins;
    spins = 0;
    while (cycle < target) begin
      @(negedge cpu_clock);
      spins++;
      if (spins > WAIT_LIMIT) begin
        $display("Timeout: no %s after %0d clock cycles", what, WAIT_LIMIT);
        $display("Something failed");
        $fatal(1);
      end
    end
  endtask

  task automatic apply_reset();
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge cpu_clock);
      check_commit("reset slot0", no_commit(), commit0);
      check_commit("reset slot1", no_commit(), commit1);
    end
    rst_n = 1'b1;
    wait_to_cycle(1, "rising edge after reset release");
  endtask

  initial begin
    int start;
    int total;
    rst_n = 1'b0;
    bundle = '0;
    bundle_vld = 1'b0;
    build_table();
    apply_reset();
    start = cycle;
    total = names.size();
    // Entry n is driven at step n and its commits are checked two steps later
    for (int n = 0; n < total + 2; n++) begin
      wait_to_cycle(start + n + 1, "falling edge for the next table step");
      if (n >= 2) begin
        check_commit({names[n-2], " slot0"}, exp0_q[n-2], commit0);
        check_commit({names[n-2], " slot1"}, exp1_q[n-2], commit1);
      end
      if (n < total) begin
        bundle = bundles[n];
        bundle_vld = vlds[n];
      end else begin
        bundle = '0;
        bundle_vld = 1'b0;
      end
    end
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk_o
);

  // Free running clock, low for the first half period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire
